// ==== aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
	input  cpuCtrlPkg::aluOpT op,
	input  rvIsaPkg::wordT a,
	input  rvIsaPkg::wordT b,
	output rvIsaPkg::wordT y,
	output logic zero
);
	import cpuCtrlPkg::*;

	always_comb begin
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR: y = a | b;
			ALU_XOR: y = a ^ b;
			ALU_SLT: y = {31'b0, $signed(a) < $signed(b)};
			default: y = a + b;
		endcase
	end

	assign zero = (a == b);  // Equal operands

endmodule

`default_nettype wire

// ==== apbHostPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module apbHostPort #(
	parameter int memWords = 256
) (
	input  logic clk,
	input  logic arstN,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  cpuCtrlPkg::hostAddrT paddr,
	input  rvIsaPkg::wordT pwdata,
	output rvIsaPkg::wordT prdata,
	output logic pready,
	output logic pslverr,
	output logic run,
	input  logic running,
	input  logic halted,
	input  logic illegal,
	input  rvIsaPkg::wordT coreAddr,
	input  logic coreWe,
	input  rvIsaPkg::wordT coreWdata,
	output logic [$clog2(memWords)-1:0] memAddr,
	output logic memWe,
	output rvIsaPkg::wordT memWdata,
	input  rvIsaPkg::wordT memRdata,
	output rvIsaPkg::regIdxT hostRegIdx,
	input  rvIsaPkg::wordT hostRegData
);
	import cpuCtrlPkg::*;

	localparam int addrW = $clog2(memWords);

	hostAddrT memOff;
	logic memHit;
	logic ctrlHit;
	logic regHit;
	logic access;
	logic slvErr;
	logic hostMemRd;
	logic hostMemWr;
	logic rdWait;

	assign memOff = paddr - MEM_BASE;
	assign memHit = memOff < hostAddrT'(memWords * 4);
	assign ctrlHit = (paddr == CTRL_ADDR);
	assign regHit = (paddr[11:7] == REG_BASE[11:7]);
	assign access = psel && penable;

	assign slvErr = (running && (memHit || regHit)) || (regHit && pwrite) ||
		!(memHit || ctrlHit || regHit);
	assign hostMemRd = memHit && !pwrite && !slvErr;
	assign hostMemWr = access && memHit && pwrite && !slvErr;

	// One wait state covers the registered memory read
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rdWait <= 1'b0;
		end else begin
			rdWait <= access && hostMemRd && !rdWait;
		end
	end

	assign pready = access && (!hostMemRd || rdWait);
	assign pslverr = pready && slvErr;
	assign run = access && pwrite && ctrlHit && pwdata[0];
	assign hostRegIdx = paddr[6:2];

	always_comb begin
		if (hostMemRd) begin
			prdata = memRdata;
		end else if (ctrlHit) begin
			prdata = {29'b0, illegal, halted, running};
		end else if (regHit && !slvErr) begin
			prdata = hostRegData;
		end else begin
			prdata = '0;
		end
	end

	// Core owns memory while it runs
	assign memAddr = running ? coreAddr[addrW+1:2] : memOff[addrW+1:2];
	assign memWe = running ? coreWe : hostMemWr;
	assign memWdata = running ? coreWdata : pwdata;

endmodule

`default_nettype wire

// ==== cpuCtrlPkg.sv ====
`default_nettype none

package cpuCtrlPkg;

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXEC,
		MEMACC,
		WRITEBACK,
		HALT
	} ctrlStateT;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} aluOpT;

	typedef logic srcASelT;
	typedef logic [2:0] srcBSelT;
	typedef logic [11:0] hostAddrT;

	localparam srcASelT SRCA_PC = 1'b0;
	localparam srcASelT SRCA_REG = 1'b1;

	localparam srcBSelT SRCB_REG = 3'd0;
	localparam srcBSelT SRCB_FOUR = 3'd1;
	localparam srcBSelT SRCB_IMMI = 3'd2;
	localparam srcBSelT SRCB_IMMS = 3'd3;
	localparam srcBSelT SRCB_IMMB = 3'd4;

	// Host address map
	localparam hostAddrT MEM_BASE = 12'h000;
	localparam hostAddrT CTRL_ADDR = 12'h800;
	localparam hostAddrT REG_BASE = 12'hC00;  // 32 words, read only

endpackage

`default_nettype wire

// ==== cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
	import rvIsaPkg::*;
	import cpuCtrlPkg::*;

	localparam int memWords = 256;
	localparam int watchdogCycles = 20000;  // Covers the longest program with a wide margin

	logic clk = 1'b0;
	logic arstN;
	logic psel;
	logic penable;
	logic pwrite;
	hostAddrT paddr;
	wordT pwdata;
	wordT prdata;
	logic pready;
	logic pslverr;

	int passCount;
	int failCount;
	int testFails;
	int seedVal;
	int waitStates;
	string testName;
	instrT prog [$];

	cpuTop #(
		.memWords(memWords)
	) cpuTop_i (
		.clk(clk),
		.arstN(arstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #5 clk = ~clk;

	function automatic instrT encR(logic [6:0] f7, funct3T f3, regIdxT rd, regIdxT rs1,
		regIdxT rs2);
		return {f7, rs2, rs1, f3, rd, OP_RTYPE};
	endfunction

	function automatic instrT encI(opcodeT op, funct3T f3, regIdxT rd, regIdxT rs1,
		logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic instrT encS(regIdxT rs2, regIdxT rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};  // SW
	endfunction

	function automatic instrT encB(regIdxT rs1, regIdxT rs2, logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OP_BRANCH};  // BEQ
	endfunction

	task automatic checkEq(string what, wordT expVal, wordT actVal);
		assert (actVal === expVal) passCount++;
		else begin
			$display("ERR %s %s: expected %h, actual %h", testName, what, expVal, actVal);
			failCount++;
		end
	endtask

	task automatic beginTest(string name);
		testName = name;
		testFails = failCount;
	endtask

	task automatic reportTest();
		$display("test %s finished with %0d failed checks", testName, failCount - testFails);
	endtask

	// Setup then access until pready
	task automatic apbTransfer(input logic wr, input hostAddrT addr, input wordT wdata,
		output wordT rdata, output logic err);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		waitStates = 0;
		@(negedge clk);
		while (!pready) begin
			waitStates++;  // Access cycles without pready
			@(negedge clk);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic writeWord(hostAddrT addr, wordT data);
		wordT rdata;
		logic err;
		apbTransfer(1'b1, addr, data, rdata, err);
		checkEq("write slverr", 32'd0, {31'b0, err});
		checkEq("write wait states", 32'd0, 32'(waitStates));
	endtask

	task automatic readWord(input hostAddrT addr, output wordT data, output logic err);
		apbTransfer(1'b0, addr, 32'd0, data, err);
	endtask

	task automatic writeProgram();
		for (int i = 0; i < prog.size(); i++) begin
			writeWord(hostAddrT'(i * 4), prog[i]);
		end
	endtask

	task automatic waitHalted(output wordT status);
		wordT st;
		logic err;
		do begin
			readWord(CTRL_ADDR, st, err);
		end while (!st[1]);
		status = st;
	endtask

	task automatic runProgram(output wordT status);
		writeWord(CTRL_ADDR, 32'd1);
		waitHalted(status);
	endtask

	task automatic testMemory();
		logic picked [memWords];
		int addrs [16];
		wordT data [16];
		wordT rdata;
		logic err;
		beginTest("memory");
		readWord(CTRL_ADDR, rdata, err);
		checkEq("control after reset", 32'd0, rdata);
		checkEq("control read wait states", 32'd0, 32'(waitStates));
		for (int i = 0; i < memWords; i++) begin
			picked[i] = 1'b0;
		end
		for (int i = 0; i < 16; i++) begin
			do begin
				addrs[i] = $urandom_range(memWords - 1);
			end while (picked[addrs[i]]);  // Distinct words only
			picked[addrs[i]] = 1'b1;
			data[i] = $urandom;
			writeWord(hostAddrT'(addrs[i] * 4), data[i]);
		end
		for (int i = 0; i < 16; i++) begin
			readWord(hostAddrT'(addrs[i] * 4), rdata, err);
			checkEq($sformatf("word %0d", addrs[i]), data[i], rdata);
			checkEq("read slverr", 32'd0, {31'b0, err});
			checkEq("read wait states", 32'd1, 32'(waitStates));
		end
		reportTest();
	endtask

	task automatic testArith();
		wordT a;
		wordT b;
		wordT rdata;
		wordT status;
		wordT expRes [6];
		logic err;
		beginTest("arith");
		prog.delete();
		prog.push_back(encI(OP_LOAD, 3'b010, 5'd1, 5'd0, 12'h200));
		prog.push_back(encI(OP_LOAD, 3'b010, 5'd2, 5'd0, 12'h204));
		prog.push_back(encR(F7_BASE, F3_ADDSUB, 5'd3, 5'd1, 5'd2));
		prog.push_back(encR(F7_SUB, F3_ADDSUB, 5'd4, 5'd1, 5'd2));
		prog.push_back(encR(F7_BASE, F3_AND, 5'd5, 5'd1, 5'd2));
		prog.push_back(encR(F7_BASE, F3_OR, 5'd6, 5'd1, 5'd2));
		prog.push_back(encR(F7_BASE, F3_XOR, 5'd7, 5'd1, 5'd2));
		prog.push_back(encR(F7_BASE, F3_SLT, 5'd8, 5'd1, 5'd2));
		for (int k = 0; k < 6; k++) begin
			prog.push_back(encS(regIdxT'(k + 3), 5'd0, 12'(12'h210 + 4 * k)));
		end
		prog.push_back({25'b0, OP_SYSTEM});  // ECALL
		writeProgram();
		for (int r = 0; r < 3; r++) begin
			a = $urandom;
			b = (r == 2) ? a : $urandom;  // Last round with equal operands
			if (r == 1) begin
				b[31] = ~a[31];  // Opposite signs tell signed from unsigned
			end
			expRes[0] = a + b;
			expRes[1] = a - b;
			expRes[2] = a & b;
			expRes[3] = a | b;
			expRes[4] = a ^ b;
			expRes[5] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			writeWord(12'h200, a);
			writeWord(12'h204, b);
			runProgram(status);
			checkEq("status", 32'd2, status);
			for (int k = 0; k < 6; k++) begin
				readWord(hostAddrT'(12'h210 + 4 * k), rdata, err);
				checkEq($sformatf("stored result %0d", k), expRes[k], rdata);
				readWord(hostAddrT'(REG_BASE + 4 * (k + 3)), rdata, err);
				checkEq($sformatf("x%0d", k + 3), expRes[k], rdata);
			end
		end
		reportTest();
	endtask

	task automatic testLoop();
		int n;
		wordT rdata;
		wordT status;
		logic err;
		beginTest("loop");
		n = $urandom_range(20, 1);
		prog.delete();
		prog.push_back(encI(OP_ADDI, 3'b000, 5'd1, 5'd0, 12'(n)));
		prog.push_back(encI(OP_ADDI, 3'b000, 5'd2, 5'd0, 12'd0));
		prog.push_back(encI(OP_ADDI, 3'b000, 5'd1, 5'd1, 12'hFFF));  // Count down
		prog.push_back(encI(OP_ADDI, 3'b000, 5'd2, 5'd2, 12'd1));
		prog.push_back(encB(5'd1, 5'd0, 13'd8));
		prog.push_back(encB(5'd0, 5'd0, 13'h1FF4));  // Back 12 bytes
		prog.push_back({25'b0, OP_SYSTEM});
		writeProgram();
		runProgram(status);
		readWord(REG_BASE + 12'd4, rdata, err);
		checkEq("counter x1", 32'd0, rdata);
		readWord(REG_BASE + 12'd8, rdata, err);
		checkEq("tally x2", 32'(n), rdata);
		reportTest();
	endtask

	task automatic testZeroReg();
		wordT rdata;
		wordT status;
		logic err;
		beginTest("x0");
		prog.delete();
		prog.push_back(encI(OP_ADDI, 3'b000, 5'd0, 5'd0, 12'd123));
		prog.push_back(encI(OP_ADDI, 3'b000, 5'd9, 5'd0, 12'd77));
		prog.push_back({25'b0, OP_SYSTEM});
		writeProgram();
		runProgram(status);
		checkEq("status", 32'd2, status);
		readWord(REG_BASE, rdata, err);
		checkEq("x0", 32'd0, rdata);
		readWord(REG_BASE + 12'd36, rdata, err);
		checkEq("x9", 32'd77, rdata);
		checkEq("register read wait states", 32'd0, 32'(waitStates));
		reportTest();
	endtask

	task automatic testErrors();
		wordT rdata;
		wordT status;
		logic err;
		beginTest("errors");
		writeWord(12'h200, 32'h1234_5678);
		prog.delete();
		prog.push_back(encI(OP_ADDI, 3'b000, 5'd1, 5'd0, 12'd200));
		prog.push_back(encI(OP_ADDI, 3'b000, 5'd1, 5'd1, 12'hFFF));
		prog.push_back(encB(5'd1, 5'd0, 13'd8));
		prog.push_back(encB(5'd0, 5'd0, 13'h1FF8));
		prog.push_back({25'b0, OP_SYSTEM});
		writeProgram();
		writeWord(CTRL_ADDR, 32'd1);
		readWord(CTRL_ADDR, rdata, err);
		checkEq("running status", 32'd1, rdata);
		readWord(12'h200, rdata, err);
		checkEq("memory read while running", 32'd1, {31'b0, err});
		apbTransfer(1'b1, 12'h200, 32'hDEAD_BEEF, rdata, err);
		checkEq("memory write while running", 32'd1, {31'b0, err});
		readWord(REG_BASE + 12'd4, rdata, err);
		checkEq("register read while running", 32'd1, {31'b0, err});
		waitHalted(status);
		readWord(12'h200, rdata, err);
		checkEq("memory kept", 32'h1234_5678, rdata);
		apbTransfer(1'b1, REG_BASE + 12'd4, 32'd5, rdata, err);
		checkEq("register window write", 32'd1, {31'b0, err});
		readWord(REG_BASE + 12'd4, rdata, err);
		checkEq("x1 after loop", 32'd0, rdata);
		readWord(12'h400, rdata, err);
		checkEq("unmapped read", 32'd1, {31'b0, err});
		prog.delete();
		prog.push_back({25'b0, 7'h7F});  // Unknown opcode
		writeProgram();
		runProgram(status);
		checkEq("illegal status", 32'd6, status);
		reportTest();
	endtask

	initial begin
		seedVal = $urandom(52898);
		arstN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		passCount = 0;
		failCount = 0;
		testFails = 0;
		waitStates = 0;
		repeat (4) @(posedge clk);
		#1;
		arstN = 1'b1;
		testMemory();
		testArith();
		testLoop();
		testZeroReg();
		testErrors();
		$display("checks passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("timeout: tests did not finish within %0d cycles", watchdogCycles);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTop #(
	parameter int memWords = 256
) (
	input  logic clk,
	input  logic arstN,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  cpuCtrlPkg::hostAddrT paddr,
	input  rvIsaPkg::wordT pwdata,
	output rvIsaPkg::wordT prdata,
	output logic pready,
	output logic pslverr
);
	import rvIsaPkg::*;

	logic run;
	logic running;
	logic halted;
	logic illegal;
	wordT coreAddr;
	logic coreWe;
	wordT coreWdata;
	logic [$clog2(memWords)-1:0] memAddr;
	logic memWe;
	wordT memWdata;
	wordT memRdata;
	regIdxT hostRegIdx;
	wordT hostRegData;

	apbHostPort #(
		.memWords(memWords)
	) host_i (
		.clk(clk),
		.arstN(arstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.run(run),
		.running(running),
		.halted(halted),
		.illegal(illegal),
		.coreAddr(coreAddr),
		.coreWe(coreWe),
		.coreWdata(coreWdata),
		.memAddr(memAddr),
		.memWe(memWe),
		.memWdata(memWdata),
		.memRdata(memRdata),
		.hostRegIdx(hostRegIdx),
		.hostRegData(hostRegData)
	);

	multiCycleCore core_i (
		.clk(clk),
		.arstN(arstN),
		.run(run),
		.memAddr(coreAddr),
		.memWe(coreWe),
		.memRe(),  // Memory reads every cycle
		.memWdata(coreWdata),
		.memRdata(memRdata),
		.hostRegIdx(hostRegIdx),
		.hostRegData(hostRegData),
		.running(running),
		.halted(halted),
		.illegal(illegal)
	);

	wordMemory #(
		.memWords(memWords)
	) mem_i (
		.clk(clk),
		.addr(memAddr),
		.we(memWe),
		.wData(memWdata),
		.rData(memRdata)
	);

endmodule

`default_nettype wire

// ==== multiCycleControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module multiCycleControl (
	input  logic clk,
	input  logic arstN,
	input  logic run,
	input  rvIsaPkg::instrT instr,
	input  logic aluZero,
	output cpuCtrlPkg::aluOpT aluOp,
	output cpuCtrlPkg::srcASelT srcASel,
	output cpuCtrlPkg::srcBSelT srcBSel,
	output logic pcWrite,
	output logic pcFromAlu,
	output logic irWrite,
	output logic memRe,
	output logic memWe,
	output logic addrFromAlu,
	output logic regWe,
	output logic wbFromMem,
	output logic running,
	output logic halted,
	output logic illegal
);
	import rvIsaPkg::*;
	import cpuCtrlPkg::*;

	ctrlStateT state;
	ctrlStateT stateNext;
	opcodeT opcode;
	funct3T funct3;
	aluOpT rTypeOp;
	logic rTypeOk;
	logic opValid;
	logic haltedQ;
	logic illegalQ;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];

	always_comb begin
		rTypeOk = (instr[31:25] == F7_BASE);
		case (funct3)
			F3_ADDSUB: begin
				rTypeOp = (instr[31:25] == F7_SUB) ? ALU_SUB : ALU_ADD;
				rTypeOk = rTypeOk || (instr[31:25] == F7_SUB);
			end
			F3_SLT: rTypeOp = ALU_SLT;
			F3_XOR: rTypeOp = ALU_XOR;
			F3_OR: rTypeOp = ALU_OR;
			F3_AND: rTypeOp = ALU_AND;
			default: begin
				rTypeOp = ALU_ADD;
				rTypeOk = 1'b0;
			end
		endcase
	end

	always_comb begin
		case (opcode)
			OP_RTYPE: opValid = rTypeOk;
			OP_ADDI, OP_LOAD, OP_STORE, OP_BRANCH: opValid = 1'b1;
			default: opValid = 1'b0;  // ECALL lands here too
		endcase
	end

	always_comb begin
		stateNext = state;
		aluOp = ALU_ADD;
		srcASel = SRCA_PC;
		srcBSel = SRCB_FOUR;
		pcWrite = 1'b0;
		pcFromAlu = 1'b1;
		irWrite = 1'b0;
		memRe = 1'b0;
		memWe = 1'b0;
		addrFromAlu = 1'b0;
		regWe = 1'b0;
		wbFromMem = 1'b0;
		case (state)
			FETCH: begin
				memRe = 1'b1;  // PC + 4 goes to aluOut
				stateNext = DECODE;
			end
			DECODE: begin
				irWrite = 1'b1;
				srcBSel = SRCB_IMMB;  // Branch target into aluOut
				pcWrite = 1'b1;  // PC + 4 from aluOut
				stateNext = opValid ? EXEC : HALT;
			end
			EXEC: begin
				srcASel = SRCA_REG;
				case (opcode)
					OP_RTYPE: begin
						srcBSel = SRCB_REG;
						aluOp = rTypeOp;
						stateNext = WRITEBACK;
					end
					OP_ADDI: begin
						srcBSel = SRCB_IMMI;
						stateNext = WRITEBACK;
					end
					OP_LOAD: begin
						srcBSel = SRCB_IMMI;
						stateNext = MEMACC;
					end
					OP_STORE: begin
						srcBSel = SRCB_IMMS;
						stateNext = MEMACC;
					end
					default: begin
						srcBSel = SRCB_REG;
						aluOp = ALU_SUB;
						pcWrite = aluZero;  // Taken BEQ
						stateNext = FETCH;
					end
				endcase
			end
			MEMACC: begin
				addrFromAlu = 1'b1;
				memRe = (opcode == OP_LOAD);
				memWe = (opcode == OP_STORE);
				stateNext = (opcode == OP_LOAD) ? WRITEBACK : FETCH;
			end
			WRITEBACK: begin
				regWe = 1'b1;
				wbFromMem = (opcode == OP_LOAD);
				stateNext = FETCH;
			end
			default: begin
				if (run) begin
					pcWrite = 1'b1;
					pcFromAlu = 1'b0;  // Restart at PC 0
					stateNext = FETCH;
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= HALT;
			haltedQ <= 1'b0;
			illegalQ <= 1'b0;
		end else begin
			state <= stateNext;
			if (state == HALT && run) begin
				haltedQ <= 1'b0;
				illegalQ <= 1'b0;
			end else if (state == DECODE && !opValid) begin
				haltedQ <= 1'b1;
				illegalQ <= (opcode != OP_SYSTEM);
			end
		end
	end

	assign running = (state != HALT);
	assign halted = haltedQ;
	assign illegal = illegalQ;

endmodule

`default_nettype wire

// ==== multiCycleCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module multiCycleCore (
	input  logic clk,
	input  logic arstN,
	input  logic run,
	output rvIsaPkg::wordT memAddr,
	output logic memWe,
	output logic memRe,
	output rvIsaPkg::wordT memWdata,
	input  rvIsaPkg::wordT memRdata,
	input  rvIsaPkg::regIdxT hostRegIdx,
	output rvIsaPkg::wordT hostRegData,
	output logic running,
	output logic halted,
	output logic illegal
);
	import rvIsaPkg::*;
	import cpuCtrlPkg::*;

	wordT pc;
	instrT ir;
	instrT curInstr;
	wordT aReg;
	wordT bReg;
	wordT aluOut;
	wordT immI;
	wordT immS;
	wordT immB;
	wordT srcA;
	wordT srcB;
	wordT aluY;
	wordT raData;
	wordT rbData;
	wordT wbData;
	regIdxT raIdx;
	logic aluZero;
	aluOpT aluOp;
	srcASelT srcASel;
	srcBSelT srcBSel;
	logic pcWrite;
	logic pcFromAlu;
	logic irWrite;
	logic addrFromAlu;
	logic regWe;
	logic wbFromMem;

	// Fetched word arrives in DECODE, IR holds it afterwards
	assign curInstr = irWrite ? memRdata : ir;

	assign immI = {{20{curInstr[31]}}, curInstr[31:20]};
	assign immS = {{20{curInstr[31]}}, curInstr[31:25], curInstr[11:7]};
	assign immB = {{19{curInstr[31]}}, curInstr[31], curInstr[7], curInstr[30:25],
		curInstr[11:8], 1'b0};

	assign srcA = (srcASel == SRCA_PC) ? pc : aReg;

	always_comb begin
		case (srcBSel)
			SRCB_FOUR: srcB = 32'd4;
			SRCB_IMMI: srcB = immI;
			SRCB_IMMS: srcB = immS;
			SRCB_IMMB: srcB = immB;
			default: srcB = bReg;
		endcase
	end

	assign raIdx = running ? curInstr[19:15] : hostRegIdx;  // Host reads while idle
	assign hostRegData = raData;
	assign wbData = wbFromMem ? memRdata : aluOut;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
			ir <= '0;
		end else begin
			if (pcWrite) begin
				pc <= pcFromAlu ? aluOut : '0;
			end
			if (irWrite) begin
				ir <= memRdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		aReg <= raData;
		bReg <= rbData;
		aluOut <= aluY;
	end

	assign memAddr = addrFromAlu ? aluOut : pc;
	assign memWdata = bReg;

	multiCycleControl control_i (
		.clk(clk),
		.arstN(arstN),
		.run(run),
		.instr(curInstr),
		.aluZero(aluZero),
		.aluOp(aluOp),
		.srcASel(srcASel),
		.srcBSel(srcBSel),
		.pcWrite(pcWrite),
		.pcFromAlu(pcFromAlu),
		.irWrite(irWrite),
		.memRe(memRe),
		.memWe(memWe),
		.addrFromAlu(addrFromAlu),
		.regWe(regWe),
		.wbFromMem(wbFromMem),
		.running(running),
		.halted(halted),
		.illegal(illegal)
	);

	aluUnit alu_i (
		.op(aluOp),
		.a(srcA),
		.b(srcB),
		.y(aluY),
		.zero(aluZero)
	);

	regFile regs_i (
		.clk(clk),
		.arstN(arstN),
		.raIdx(raIdx),
		.rbIdx(curInstr[24:20]),
		.wIdx(ir[11:7]),
		.we(regWe),
		.wData(wbData),
		.raData(raData),
		.rbData(rbData)
	);

endmodule

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  logic clk,
	input  logic arstN,
	input  rvIsaPkg::regIdxT raIdx,
	input  rvIsaPkg::regIdxT rbIdx,
	input  rvIsaPkg::regIdxT wIdx,
	input  logic we,
	input  rvIsaPkg::wordT wData,
	output rvIsaPkg::wordT raData,
	output rvIsaPkg::wordT rbData
);
	import rvIsaPkg::*;

	wordT regs [32];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wIdx != '0) begin
			regs[wIdx] <= wData;  // x0 stays zero
		end
	end

	assign raData = regs[raIdx];
	assign rbData = regs[rbIdx];

endmodule

`default_nettype wire

// ==== rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

	typedef logic [31:0] instrT;
	typedef logic [4:0] regIdxT;
	typedef logic [31:0] wordT;
	typedef logic [6:0] opcodeT;
	typedef logic [2:0] funct3T;

	// Major opcodes
	localparam opcodeT OP_RTYPE = 7'b0110011;
	localparam opcodeT OP_ADDI = 7'b0010011;
	localparam opcodeT OP_LOAD = 7'b0000011;
	localparam opcodeT OP_STORE = 7'b0100011;
	localparam opcodeT OP_BRANCH = 7'b1100011;
	localparam opcodeT OP_SYSTEM = 7'b1110011;

	// R-type minor opcodes
	localparam funct3T F3_ADDSUB = 3'b000;
	localparam funct3T F3_SLT = 3'b010;
	localparam funct3T F3_XOR = 3'b100;
	localparam funct3T F3_OR = 3'b110;
	localparam funct3T F3_AND = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB = 7'b0100000;  // Only with F3_ADDSUB

endpackage

`default_nettype wire

// ==== verilog.f ====
rvIsaPkg.sv
cpuCtrlPkg.sv
aluUnit.sv
regFile.sv
multiCycleControl.sv
wordMemory.sv
multiCycleCore.sv
apbHostPort.sv
cpuTop.sv
cpuTb.sv

// ==== wordMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module wordMemory #(
	parameter int memWords = 256
) (
	input  logic clk,
	input  logic [$clog2(memWords)-1:0] addr,
	input  logic we,
	input  rvIsaPkg::wordT wData,
	output rvIsaPkg::wordT rData
);
	import rvIsaPkg::*;

	wordT mem [memWords];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wData;
		end
		rData <= mem[addr];  // Old data on a write
	end

endmodule

`default_nettype wire
